// File: Makefile
VERILATOR ?= verilator
TOP       ?= l2cache_tb
FILELIST  ?= l2cache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$($(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/l2cache_ctrl.sv
`timescale 1ns/10ps
`include "l2cache_params.svh"

module l2cache_ctrl (
    input  logic                          clk,
    input  logic                          arst_n,
    input  l2cache_pkg::req_src_e         pend_src,
    input  l2cache_pkg::req_src_e         buf_src,
    input  logic                          hit,
    input  logic [$clog2(`L2_WAYS)-1:0]   hit_way,
    input  logic [$clog2(`L2_WAYS)-1:0]   victim_way,
    input  logic                          victim_dirty,
    input  logic                          mem_addr_ok_r,
    input  logic                          mem_addr_ok_w,
    input  logic                          mem_data_ok,
    output logic                          buf_load,
    output logic                          i_addr_ok,
    output logic                          d_addr_ok,
    output logic                          i_data_ok,
    output logic                          d_data_ok,
    output logic                          tag_we,
    output logic                          data_we,
    output logic                          fill,
    output logic                          set_dirty,
    output logic                          plru_touch,
    output logic [$clog2(`L2_WAYS)-1:0]   sel_way,
    output logic                          mem_req_r,
    output logic                          mem_req_w
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL,
        ST_RESPOND
    } state_e;

    state_e                        state;
    state_e                        state_nxt;
    logic [$clog2(`L2_WAYS)-1:0]   way_q;
    logic                          rd_sent;
    logic                          is_wr;

    assign is_wr = (buf_src == l2cache_pkg::SRC_D_WR);

    // Way is fixed at lookup and kept until the response
    assign sel_way = (state == ST_LOOKUP) ? (hit ? hit_way : victim_way) : way_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            way_q   <= '0;
            rd_sent <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ST_LOOKUP) begin
                way_q <= sel_way;
            end
            if (state != ST_REFILL) begin
                rd_sent <= 1'b0;
            end else if (mem_addr_ok_r) begin
                rd_sent <= 1'b1;
            end
        end
    end

    always_comb begin
        state_nxt  = state;
        buf_load   = 1'b0;
        i_addr_ok  = 1'b0;
        d_addr_ok  = 1'b0;
        tag_we     = 1'b0;
        data_we    = 1'b0;
        fill       = 1'b0;
        set_dirty  = 1'b0;
        plru_touch = 1'b0;
        case (state)
            ST_IDLE: begin
                if (pend_src != l2cache_pkg::SRC_NONE) begin
                    buf_load  = 1'b1;
                    i_addr_ok = (pend_src == l2cache_pkg::SRC_I_RD);
                    d_addr_ok = (pend_src != l2cache_pkg::SRC_I_RD);
                    state_nxt = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    plru_touch = 1'b1;
                    data_we    = is_wr;
                    set_dirty  = is_wr;
                    state_nxt  = ST_RESPOND;
                end else if (victim_dirty) begin
                    state_nxt = ST_WRITEBACK;
                end else begin
                    state_nxt = ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                if (mem_addr_ok_w) begin
                    state_nxt = ST_REFILL;
                end
            end
            ST_REFILL: begin
                // Store word of a write miss goes in with the line
                if (mem_data_ok) begin
                    fill       = 1'b1;
                    tag_we     = 1'b1;
                    plru_touch = 1'b1;
                    set_dirty  = is_wr;
                    state_nxt  = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    assign mem_req_w = (state == ST_WRITEBACK);
    assign mem_req_r = (state == ST_REFILL) && !rd_sent;
    assign i_data_ok = (state == ST_RESPOND) && (buf_src == l2cache_pkg::SRC_I_RD);
    assign d_data_ok = (state == ST_RESPOND) && buf_src[1];

endmodule

// File: design/l2cache_data_array.sv
`timescale 1ns/10ps
`include "l2cache_params.svh"

module l2cache_data_array (
    input  logic                          clk,
    input  l2cache_pkg::req_addr_u        buf_addr,
    input  logic [31:0]                   buf_wdata,
    input  logic [3:0]                    buf_wstrb,
    input  l2cache_pkg::line_t            mem_rdata,
    input  logic                          data_we,
    input  logic                          fill,
    input  logic [$clog2(`L2_WAYS)-1:0]   sel_way,
    output l2cache_pkg::half_t            rdata,
    output l2cache_pkg::line_t            victim_line
);

    localparam int SETS    = 1 << `L2_INDEX_W;
    localparam int HALF_BW = 32 * `L2_HALF_W;

    l2cache_pkg::line_t      lines [SETS][`L2_WAYS];
    l2cache_pkg::line_t      cur_line;
    l2cache_pkg::line_t      merged;
    logic [`L2_INDEX_W-1:0]  idx;
    logic [`L2_OFFSET_W-1:0] off;

    assign idx      = buf_addr.f.index;
    assign off      = buf_addr.f.offset;
    assign cur_line = lines[idx][sel_way];

    // Byte merge onto either the stored line or the incoming refill
    always_comb begin
        merged = fill ? mem_rdata : cur_line;
        for (int b = 0; b < 4; b++) begin
            if (buf_wstrb[b]) begin
                merged[32*off + 8*b +: 8] = buf_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill || data_we) begin
            lines[idx][sel_way] <= merged;
        end
    end

    // Upper offset bit picks the half line
    assign rdata       = cur_line[HALF_BW*off[`L2_OFFSET_W-1] +: HALF_BW];
    assign victim_line = cur_line;

endmodule

// File: design/l2cache_params.svh
`ifndef L2CACHE_PARAMS_SVH
`define L2CACHE_PARAMS_SVH

// Cache geometry
`define L2_WAYS     4
`define L2_INDEX_W  2
`define L2_OFFSET_W 3

// Words handed back to a first-level cache per read
`define L2_HALF_W   4

// 32 minus index, word offset and the two byte bits
`define L2_TAG_W    25

`endif

// File: design/l2cache_pkg.sv
`include "l2cache_params.svh"

package l2cache_pkg;

    typedef struct packed {
        logic [`L2_TAG_W-1:0]    tag;
        logic [`L2_INDEX_W-1:0]  index;
        logic [`L2_OFFSET_W-1:0] offset;
        logic [1:0]              byte_sel;
    } addr_fields_t;

    // Raw word for memory, fields for the lookup
    typedef union packed {
        logic [31:0]  raw;
        addr_fields_t f;
    } req_addr_u;

    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_I_RD = 2'd1,
        SRC_D_RD = 2'd2,
        SRC_D_WR = 2'd3
    } req_src_e;

    typedef logic [32*(1<<`L2_OFFSET_W)-1:0] line_t;
    typedef logic [32*`L2_HALF_W-1:0]        half_t;

endpackage

// File: design/l2cache_plru.sv
`timescale 1ns/10ps
`include "l2cache_params.svh"

module l2cache_plru (
    input  logic                          clk,
    input  logic                          arst_n,
    input  l2cache_pkg::req_addr_u        buf_addr,
    input  logic                          plru_touch,
    input  logic [$clog2(`L2_WAYS)-1:0]   sel_way,
    input  logic [`L2_WAYS-1:0]           tag_valid,
    output logic [$clog2(`L2_WAYS)-1:0]   victim_way
);

    localparam int SETS = 1 << `L2_INDEX_W;

    // Bit 0 is the root, bit 1 the left pair, bit 2 the right pair
    logic [SETS-1:0][2:0]   tree;
    logic [2:0]             cur;
    logic [`L2_INDEX_W-1:0] idx;

    assign idx = buf_addr.f.index;
    assign cur = tree[idx];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tree <= '0;
        end else if (plru_touch) begin
            tree[idx][0] <= ~sel_way[1];
            if (sel_way[1]) begin
                tree[idx][2] <= ~sel_way[0];
            end else begin
                tree[idx][1] <= ~sel_way[0];
            end
        end
    end

    // Empty way first, then follow the tree
    always_comb begin
        victim_way = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (!tag_valid[w]) begin
                victim_way = w[$clog2(`L2_WAYS)-1:0];
            end
        end
    end

endmodule

// File: design/l2cache_req_buf.sv
`timescale 1ns/10ps
`include "l2cache_params.svh"

module l2cache_req_buf (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          i_req,
    input  logic [31:0]                   i_addr,
    input  logic                          d_req,
    input  logic                          d_wr,
    input  logic [31:0]                   d_addr,
    input  logic [31:0]                   d_wdata,
    input  logic [3:0]                    d_wstrb,
    input  logic                          buf_load,
    output l2cache_pkg::req_src_e         pend_src,
    output l2cache_pkg::req_src_e         buf_src,
    output l2cache_pkg::req_addr_u        buf_addr,
    output logic [31:0]                   buf_wdata,
    output logic [3:0]                    buf_wstrb,
    output logic [31:0]                   mem_addr_r
);

    // Data cache wins a tie
    always_comb begin
        if (d_req) begin
            pend_src = d_wr ? l2cache_pkg::SRC_D_WR : l2cache_pkg::SRC_D_RD;
        end else if (i_req) begin
            pend_src = l2cache_pkg::SRC_I_RD;
        end else begin
            pend_src = l2cache_pkg::SRC_NONE;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_src <= l2cache_pkg::SRC_NONE;
        end else if (buf_load) begin
            buf_src <= pend_src;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_load) begin
            buf_addr.raw <= d_req ? d_addr : i_addr;
            buf_wdata    <= d_wdata;
            // Reads carry no strobes
            buf_wstrb    <= (d_req && d_wr) ? d_wstrb : 4'b0000;
        end
    end

    // Refill address is line aligned
    assign mem_addr_r = {buf_addr.f.tag, buf_addr.f.index, {(`L2_OFFSET_W+2){1'b0}}};

endmodule

// File: design/l2cache_tag_array.sv
`timescale 1ns/10ps
`include "l2cache_params.svh"

module l2cache_tag_array (
    input  logic                          clk,
    input  logic                          arst_n,
    input  l2cache_pkg::req_addr_u        buf_addr,
    input  logic                          tag_we,
    input  logic                          set_dirty,
    input  logic [$clog2(`L2_WAYS)-1:0]   sel_way,
    input  logic [$clog2(`L2_WAYS)-1:0]   victim_way,
    output logic                          hit,
    output logic [$clog2(`L2_WAYS)-1:0]   hit_way,
    output logic                          victim_dirty,
    output logic [`L2_TAG_W-1:0]          victim_tag,
    output logic [`L2_WAYS-1:0]           tag_valid,
    output logic [31:0]                   mem_addr_w
);

    localparam int SETS = 1 << `L2_INDEX_W;

    logic [`L2_TAG_W-1:0]           tags [SETS][`L2_WAYS];
    logic [SETS-1:0][`L2_WAYS-1:0]  valid;
    logic [SETS-1:0][`L2_WAYS-1:0]  dirty;
    logic [`L2_INDEX_W-1:0]         idx;
    logic [`L2_WAYS-1:0]            match;

    assign idx = buf_addr.f.index;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            dirty <= '0;
        end else if (tag_we) begin
            valid[idx][sel_way] <= 1'b1;
            dirty[idx][sel_way] <= set_dirty;
        end else if (set_dirty) begin
            dirty[idx][sel_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[idx][sel_way] <= buf_addr.f.tag;
        end
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            match[w] = valid[idx][w] && (tags[idx][w] == buf_addr.f.tag);
            if (match[w]) begin
                hit_way = w[$clog2(`L2_WAYS)-1:0];
            end
        end
    end

    assign hit          = |match;
    assign tag_valid    = valid[idx];
    assign victim_dirty = valid[idx][victim_way] && dirty[idx][victim_way];
    assign victim_tag   = tags[idx][victim_way];
    assign mem_addr_w   = {victim_tag, idx, {(`L2_OFFSET_W+2){1'b0}}};

endmodule

// File: design/l2cache_top.sv
`timescale 1ns/10ps
`include "l2cache_params.svh"

module l2cache_top (
    input  logic                clk,
    input  logic                arst_n,
    // Instruction cache
    input  logic                i_req,
    input  logic [31:0]         i_addr,
    output logic                i_addr_ok,
    output logic                i_data_ok,
    // Data cache
    input  logic                d_req,
    input  logic                d_wr,
    input  logic [31:0]         d_addr,
    input  logic [31:0]         d_wdata,
    input  logic [3:0]          d_wstrb,
    output logic                d_addr_ok,
    output logic                d_data_ok,
    output l2cache_pkg::half_t  rdata,
    // Memory
    output logic                mem_req_r,
    output logic [31:0]         mem_addr_r,
    input  logic                mem_addr_ok_r,
    input  l2cache_pkg::line_t  mem_rdata,
    input  logic                mem_data_ok,
    output logic                mem_req_w,
    output logic [31:0]         mem_addr_w,
    output l2cache_pkg::line_t  mem_wdata,
    input  logic                mem_addr_ok_w
);

    localparam int WAY_W = $clog2(`L2_WAYS);

    l2cache_pkg::req_src_e  pend_src;
    l2cache_pkg::req_src_e  buf_src;
    l2cache_pkg::req_addr_u buf_addr;
    logic [31:0]            buf_wdata;
    logic [3:0]             buf_wstrb;
    logic                   buf_load;
    logic                   hit;
    logic [WAY_W-1:0]       hit_way;
    logic [WAY_W-1:0]       victim_way;
    logic [WAY_W-1:0]       sel_way;
    logic                   victim_dirty;
    logic [`L2_WAYS-1:0]    tag_valid;
    logic                   tag_we;
    logic                   data_we;
    logic                   fill;
    logic                   set_dirty;
    logic                   plru_touch;

    l2cache_req_buf req_buf_i (
        .clk(clk), .arst_n(arst_n),
        .i_req(i_req), .i_addr(i_addr),
        .d_req(d_req), .d_wr(d_wr), .d_addr(d_addr),
        .d_wdata(d_wdata), .d_wstrb(d_wstrb),
        .buf_load(buf_load),
        .pend_src(pend_src), .buf_src(buf_src), .buf_addr(buf_addr),
        .buf_wdata(buf_wdata), .buf_wstrb(buf_wstrb),
        .mem_addr_r(mem_addr_r)
    );

    l2cache_ctrl ctrl_i (
        .clk(clk), .arst_n(arst_n),
        .pend_src(pend_src), .buf_src(buf_src),
        .hit(hit), .hit_way(hit_way),
        .victim_way(victim_way), .victim_dirty(victim_dirty),
        .mem_addr_ok_r(mem_addr_ok_r), .mem_addr_ok_w(mem_addr_ok_w),
        .mem_data_ok(mem_data_ok),
        .buf_load(buf_load),
        .i_addr_ok(i_addr_ok), .d_addr_ok(d_addr_ok),
        .i_data_ok(i_data_ok), .d_data_ok(d_data_ok),
        .tag_we(tag_we), .data_we(data_we), .fill(fill),
        .set_dirty(set_dirty), .plru_touch(plru_touch), .sel_way(sel_way),
        .mem_req_r(mem_req_r), .mem_req_w(mem_req_w)
    );

    l2cache_tag_array tag_array_i (
        .clk(clk), .arst_n(arst_n),
        .buf_addr(buf_addr), .tag_we(tag_we), .set_dirty(set_dirty),
        .sel_way(sel_way), .victim_way(victim_way),
        .hit(hit), .hit_way(hit_way),
        .victim_dirty(victim_dirty), .victim_tag(),
        .tag_valid(tag_valid), .mem_addr_w(mem_addr_w)
    );

    l2cache_data_array data_array_i (
        .clk(clk),
        .buf_addr(buf_addr), .buf_wdata(buf_wdata), .buf_wstrb(buf_wstrb),
        .mem_rdata(mem_rdata), .data_we(data_we), .fill(fill), .sel_way(sel_way),
        .rdata(rdata), .victim_line(mem_wdata)
    );

    l2cache_plru plru_i (
        .clk(clk), .arst_n(arst_n),
        .buf_addr(buf_addr), .plru_touch(plru_touch), .sel_way(sel_way),
        .tag_valid(tag_valid), .victim_way(victim_way)
    );

endmodule

// File: l2cache.f
+incdir+design
design/l2cache_pkg.sv
design/l2cache_req_buf.sv
design/l2cache_ctrl.sv
design/l2cache_tag_array.sv
design/l2cache_data_array.sv
design/l2cache_plru.sv
design/l2cache_top.sv
sim/l2cache_sva.sv
sim/l2cache_checker.sv
sim/l2cache_tb.sv

// File: sim/l2cache_checker.sv
`timescale 1ns/10ps

module l2cache_checker (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [31:0]        i_addr,
    input  logic               i_addr_ok,
    input  logic               i_data_ok,
    input  logic               d_req,
    input  logic               d_wr,
    input  logic [31:0]        d_addr,
    input  logic [31:0]        d_wdata,
    input  logic [3:0]         d_wstrb,
    input  logic               d_addr_ok,
    input  logic               d_data_ok,
    input  l2cache_pkg::half_t rdata,
    input  logic               mem_req_r,
    input  logic               mem_req_w,
    input  logic [31:0]        mem_addr_w,
    input  l2cache_pkg::line_t mem_wdata,
    input  logic               mem_addr_ok_w,
    input  logic               exp_hit,
    input  logic               exp_wb,
    input  logic [31:0]        exp_wb_addr,
    output int unsigned        data_errs,
    output int unsigned        proto_errs
);

    // Words written so far, keyed by word address
    logic [31:0] ref_mem [int unsigned];
    logic [31:0] cur_addr;
    logic        cur_is_i;
    logic        cur_rd;
    logic        busy;
    logic        saw_r;
    logic        saw_w;
    int unsigned lat;

    // Reset content is the byte address with the upper half inverted
    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        if (ref_mem.exists(addr[31:2])) begin
            return ref_mem[addr[31:2]];
        end
        return {~addr[31:16], addr[15:2], 2'b00};
    endfunction

    task automatic apply_write(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] strb);
        logic [31:0] w;
        w = ref_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        ref_mem[addr[31:2]] = w;
    endtask

    task automatic check_read();
        l2cache_pkg::half_t want;
        logic [31:0]        base;
        base = {cur_addr[31:4], 4'h0};
        for (int k = 0; k < 4; k++) begin
            want[32*k +: 32] = ref_word(base + 32'(4*k));
        end
        if (rdata !== want) begin
            data_errs++;
            $display("MISMATCH rdata at %h: expected %h, got %h", cur_addr, want, rdata);
        end
    endtask

    task automatic check_writeback();
        l2cache_pkg::line_t want;
        for (int k = 0; k < 8; k++) begin
            want[32*k +: 32] = ref_word(exp_wb_addr + 32'(4*k));
        end
        if (mem_addr_w !== exp_wb_addr) begin
            data_errs++;
            $display("MISMATCH mem_addr_w: expected %h, got %h", exp_wb_addr, mem_addr_w);
        end
        if (mem_wdata !== want) begin
            data_errs++;
            $display("MISMATCH mem_wdata at %h: expected %h, got %h", exp_wb_addr, want,
                     mem_wdata);
        end
    endtask

    task automatic start_txn(input logic [31:0] addr, input logic is_i, input logic rd);
        cur_addr = addr;
        cur_is_i = is_i;
        cur_rd   = rd;
        busy     = 1'b1;
        lat      = 0;
        saw_r    = 1'b0;
        saw_w    = 1'b0;
    endtask

    task automatic end_txn();
        if (!busy) begin
            proto_errs++;
            $display("data_ok with no request outstanding");
            return;
        end
        if (i_data_ok != cur_is_i) begin
            proto_errs++;
            $display("data_ok on the wrong port for address %h", cur_addr);
        end
        if (cur_rd) begin
            check_read();
        end
        if (exp_hit) begin
            if (lat != 2) begin
                proto_errs++;
                $display("hit at %h answered %0d cycles after addr_ok, not 2", cur_addr, lat);
            end
            if (saw_r || saw_w) begin
                proto_errs++;
                $display("memory request during a hit at %h", cur_addr);
            end
        end else begin
            if (!saw_r) begin
                proto_errs++;
                $display("miss at %h did not refill from memory", cur_addr);
            end
            if (saw_w != exp_wb) begin
                proto_errs++;
                $display("write-back %s on the miss at %h",
                         exp_wb ? "missing" : "not expected", cur_addr);
            end
        end
        busy = 1'b0;
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            busy       = 1'b0;
            lat        = 0;
            saw_r      = 1'b0;
            saw_w      = 1'b0;
            data_errs  = 0;
            proto_errs = 0;
        end else begin
            if (busy) begin
                lat++;
                saw_r |= mem_req_r;
                saw_w |= mem_req_w;
            end
            if (mem_req_w && mem_addr_ok_w) begin
                check_writeback();
            end
            if (i_data_ok || d_data_ok) begin
                end_txn();
            end
            // Data side has priority
            if (i_addr_ok && d_req) begin
                proto_errs++;
                $display("i_addr_ok given while d_req was waiting");
            end
            if (i_addr_ok) begin
                start_txn(i_addr, 1'b1, 1'b1);
            end
            if (d_addr_ok) begin
                start_txn(d_addr, 1'b0, !d_wr);
                if (d_wr) begin
                    apply_write(d_addr, d_wdata, d_wstrb);
                end
            end
        end
    end

endmodule

// File: sim/l2cache_sva.sv
`timescale 1ns/10ps

module l2cache_sva (
    input logic clk,
    input logic arst_n,
    input logic i_req,
    input logic d_req,
    input logic i_addr_ok,
    input logic d_addr_ok,
    input logic i_data_ok,
    input logic d_data_ok,
    input logic mem_req_r,
    input logic mem_addr_ok_r,
    input logic mem_req_w,
    input logic mem_addr_ok_w
);

    int unsigned fail_count = 0;

    // Grant only to a waiting requester
    assert property (@(posedge clk) disable iff (!arst_n)
        !(i_addr_ok && !i_req) && !(d_addr_ok && !d_req))
    else begin
        fail_count++;
        $error("addr_ok given without its request");
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(i_addr_ok && d_addr_ok))
    else begin
        fail_count++;
        $error("both addr_ok high in one cycle");
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_r && !mem_addr_ok_r |=> mem_req_r)
    else begin
        fail_count++;
        $error("mem_req_r dropped before mem_addr_ok_r");
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_w && !mem_addr_ok_w |=> mem_req_w)
    else begin
        fail_count++;
        $error("mem_req_w dropped before mem_addr_ok_w");
    end

    // Quiet handshakes while in reset
    assert property (@(posedge clk) !arst_n |-> !(i_addr_ok || d_addr_ok || i_data_ok
        || d_data_ok || mem_req_r || mem_req_w))
    else begin
        fail_count++;
        $error("handshake output high during reset");
    end

endmodule

bind l2cache_top l2cache_sva sva_i (
    .clk(clk), .arst_n(arst_n), .i_req(i_req), .d_req(d_req),
    .i_addr_ok(i_addr_ok), .d_addr_ok(d_addr_ok),
    .i_data_ok(i_data_ok), .d_data_ok(d_data_ok),
    .mem_req_r(mem_req_r), .mem_addr_ok_r(mem_addr_ok_r),
    .mem_req_w(mem_req_w), .mem_addr_ok_w(mem_addr_ok_w)
);

// File: sim/l2cache_tb.sv
`timescale 1ns/10ps

module l2cache_tb;

    localparam int NUM_TESTS = 18;
    localparam int CYCLE_NS  = 8;
    localparam logic [1:0] PORT_I = 2'd0;
    localparam logic [1:0] PORT_D = 2'd1;
    // Both ports raise req in the same cycle
    localparam logic [1:0] PORT_B = 2'd2;

    typedef struct packed {
        logic [1:0]  port;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic        hit;
        logic        wb;
        logic [31:0] wb_addr;
    } entry_t;

    // port, wr, addr, wdata, strb, expected hit, expected write-back and its line address
    localparam entry_t TESTS [NUM_TESTS] = '{
        '{PORT_I, 1'b0, 32'h0000_1024, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b0, 32'h0000_1030, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b1, 32'h0000_1028, 32'hAABB_CCDD, 4'b0101, 1'b1, 1'b0, 32'h0000_0000},
        '{PORT_I, 1'b0, 32'h0000_1028, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b1, 32'h0000_2044, 32'h1122_3344, 4'b1100, 1'b0, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b0, 32'h0000_2040, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b1, 32'h0000_4000, 32'hDEAD_BEEF, 4'b1111, 1'b0, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b0, 32'h0000_4084, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0000_0000},
        '{PORT_I, 1'b0, 32'h0000_4108, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b1, 32'h0000_418C, 32'h0102_0304, 4'b0011, 1'b0, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b0, 32'h0000_4210, 32'h0000_0000, 4'b0000, 1'b0, 1'b1, 32'h0000_4000},
        '{PORT_I, 1'b0, 32'h0000_4000, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b0, 32'h0000_4180, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b0, 32'h0000_4300, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b0, 32'h0000_4380, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b0, 32'h0000_4400, 32'h0000_0000, 4'b0000, 1'b0, 1'b0, 32'h0000_0000},
        '{PORT_D, 1'b0, 32'h0000_4480, 32'h0000_0000, 4'b0000, 1'b0, 1'b1, 32'h0000_4180},
        '{PORT_B, 1'b0, 32'h0000_103C, 32'h0000_0000, 4'b0000, 1'b1, 1'b0, 32'h0000_0000}
    };

    logic               clk;
    logic               arst_n;
    logic               i_req;
    logic [31:0]        i_addr;
    logic               i_addr_ok;
    logic               i_data_ok;
    logic               d_req;
    logic               d_wr;
    logic [31:0]        d_addr;
    logic [31:0]        d_wdata;
    logic [3:0]         d_wstrb;
    logic               d_addr_ok;
    logic               d_data_ok;
    l2cache_pkg::half_t rdata;
    logic               mem_req_r;
    logic [31:0]        mem_addr_r;
    logic               mem_addr_ok_r;
    l2cache_pkg::line_t mem_rdata;
    logic               mem_data_ok;
    logic               mem_req_w;
    logic [31:0]        mem_addr_w;
    l2cache_pkg::line_t mem_wdata;
    logic               mem_addr_ok_w;
    logic               exp_hit;
    logic               exp_wb;
    logic [31:0]        exp_wb_addr;
    int unsigned        data_errs;
    int unsigned        proto_errs;
    int unsigned        sva_errs;
    logic [31:0]        mem_words [int unsigned];
    logic [31:0]        rng_state = 32'd74421;

    l2cache_top l2cache_top_i (.*);

    l2cache_checker check_i (
        .clk(clk), .arst_n(arst_n),
        .i_addr(i_addr), .i_addr_ok(i_addr_ok), .i_data_ok(i_data_ok),
        .d_req(d_req), .d_wr(d_wr), .d_addr(d_addr), .d_wdata(d_wdata),
        .d_wstrb(d_wstrb), .d_addr_ok(d_addr_ok), .d_data_ok(d_data_ok),
        .rdata(rdata), .mem_req_r(mem_req_r), .mem_req_w(mem_req_w),
        .mem_addr_w(mem_addr_w), .mem_wdata(mem_wdata), .mem_addr_ok_w(mem_addr_ok_w),
        .exp_hit(exp_hit), .exp_wb(exp_wb), .exp_wb_addr(exp_wb_addr),
        .data_errs(data_errs), .proto_errs(proto_errs)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // 1 to 4 cycles, then 1 ns into the cycle
    task automatic mem_delay();
        rng_state = xorshift32(rng_state);
        repeat (1 + rng_state % 4) @(posedge clk);
        #1;
    endtask

    function automatic l2cache_pkg::line_t fetch_line(input logic [31:0] addr);
        l2cache_pkg::line_t line;
        logic [31:0]        a;
        for (int k = 0; k < 8; k++) begin
            a = addr + 32'(4*k);
            if (mem_words.exists(a[31:2])) begin
                line[32*k +: 32] = mem_words[a[31:2]];
            end else begin
                line[32*k +: 32] = {~a[31:16], a[15:2], 2'b00};
            end
        end
        return line;
    endfunction

    task automatic store_line(input logic [31:0] addr, input l2cache_pkg::line_t line);
        logic [31:0] a;
        for (int k = 0; k < 8; k++) begin
            a = addr + 32'(4*k);
            mem_words[a[31:2]] = line[32*k +: 32];
        end
    endtask

    task automatic run_entry(input entry_t e);
        @(posedge clk);
        #1;
        exp_hit     = e.hit;
        exp_wb      = e.wb;
        exp_wb_addr = e.wb_addr;
        if (e.port != PORT_I) begin
            d_req   = 1'b1;
            d_wr    = e.wr;
            d_addr  = e.addr;
            d_wdata = e.wdata;
            d_wstrb = e.strb;
        end
        if (e.port != PORT_D) begin
            i_req  = 1'b1;
            i_addr = e.addr;
        end
        if (e.port != PORT_I) begin
            do begin
                @(posedge clk);
            end while (!d_addr_ok);
            #1 d_req = 1'b0;
            if (e.port == PORT_D) begin
                do begin
                    @(posedge clk);
                end while (!d_data_ok);
            end
        end
        if (e.port != PORT_D) begin
            do begin
                @(posedge clk);
            end while (!i_addr_ok);
            #1 i_req = 1'b0;
            do begin
                @(posedge clk);
            end while (!i_data_ok);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CYCLE_NS / 2) clk = ~clk;
    end

    // Memory responder
    initial begin
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rdata     = '0;
        forever begin
            @(posedge clk);
            if (mem_req_w) begin
                mem_delay();
                store_line(mem_addr_w, mem_wdata);
                mem_addr_ok_w = 1'b1;
                @(posedge clk);
                #1 mem_addr_ok_w = 1'b0;
            end else if (mem_req_r) begin
                mem_delay();
                mem_addr_ok_r = 1'b1;
                @(posedge clk);
                #1 mem_addr_ok_r = 1'b0;
                mem_delay();
                mem_rdata   = fetch_line(mem_addr_r);
                mem_data_ok = 1'b1;
                @(posedge clk);
                #1 mem_data_ok = 1'b0;
            end
        end
    end

    initial begin
        arst_n      = 1'b0;
        i_req       = 1'b0;
        i_addr      = '0;
        d_req       = 1'b0;
        d_wr        = 1'b0;
        d_addr      = '0;
        d_wdata     = '0;
        d_wstrb     = '0;
        exp_hit     = 1'b0;
        exp_wb      = 1'b0;
        exp_wb_addr = '0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
        for (int n = 0; n < NUM_TESTS; n++) begin
            run_entry(TESTS[n]);
        end
        repeat (4) @(posedge clk);
        sva_errs = l2cache_top_i.sva_i.fail_count;
        $display("errors: data %0d, protocol %0d, assertion %0d",
                 data_errs, proto_errs, sva_errs);
        if (data_errs + proto_errs + sva_errs == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(NUM_TESTS * 60 * CYCLE_NS);
        $display("timeout: run still busy after %0d ns", NUM_TESTS * 60 * CYCLE_NS);
        $display("errors: data %0d, protocol %0d", data_errs, proto_errs);
        $display("tests failed");
        $finish;
    end

endmodule
